//--- pifo_pkg.sv
`default_nettype none

package pifo_pkg;

   // -------------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------------
   localparam int PTW     = 16;   // Priority value
   localparam int CTW     = 10;   // Items below and in an entry
   localparam int ADW     = 4;    // Row address, top may override
   localparam int N_PORTS = 4;    // Entries per row, one per child

   typedef logic [PTW-1:0]             value_t;
   typedef logic [CTW-1:0]             count_t;
   typedef logic [$clog2(N_PORTS)-1:0] port_t;

   // All ones marks an unused entry
   localparam value_t EMPTY_VALUE = '1;

   // -------------------------------------------------------------------------
   // Row layout
   // -------------------------------------------------------------------------
   // Value in the low bits of each entry
   typedef struct packed {
      count_t count;
      value_t value;
   } entry_t;

   typedef entry_t [N_PORTS-1:0] row_t;   // Entry 0 in the low bits

   // -------------------------------------------------------------------------
   // Node FSM
   // -------------------------------------------------------------------------
   typedef enum logic [1:0] {
      IDLE = 2'b00,
      PUSH = 2'b01,   // Row update, optional child push
      POP  = 2'b11,   // Result out, child popped
      WB   = 2'b10    // Child answer written back
   } state_t;

endpackage

`default_nettype wire

//--- pifo_row_if.sv
`timescale 1ns/1ps
`default_nettype none

// Row read and write between FSM, update logic and storage
interface pifo_row_if #(
   parameter int ADW = 4
) ();

   logic                 rd_en;
   logic [ADW-1:0]       rd_addr;
   pifo_pkg::row_t       rd_row;    // Valid the cycle after rd_en, held
   logic                 wr_en;
   logic [ADW-1:0]       wr_addr;
   pifo_pkg::row_t       wr_row;

   modport ctrl (output rd_en, rd_addr, wr_en, wr_addr);

   modport upd  (input rd_row, output wr_row);

   modport ram  (input rd_en, rd_addr, wr_en, wr_addr, wr_row,
                 output rd_row);

endinterface

`default_nettype wire

//--- pifo_node_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_node_ctrl #(
   parameter int ADW = 4
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_push,          // Parent push pulse
   input  logic             i_pop,           // Parent pop pulse
   input  pifo_pkg::value_t i_push_value,
   input  logic [ADW-1:0]   i_my_addr,
   pifo_row_if.ctrl         row,
   output pifo_pkg::state_t o_state,
   output pifo_pkg::value_t o_push_latch,
   output logic [ADW-1:0]   o_node_addr
);

   pifo_pkg::state_t state;
   logic             accept;

   // -------------------------------------------------------------------------
   // Accept rule
   // -------------------------------------------------------------------------
   // Exactly one command, and not while the child pop is outstanding
   assign accept = (i_push ^ i_pop) && (state != pifo_pkg::POP);

   // -------------------------------------------------------------------------
   // State register
   // -------------------------------------------------------------------------
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= pifo_pkg::IDLE;
      end else if (accept) begin
         state <= i_push ? pifo_pkg::PUSH : pifo_pkg::POP;
      end else if (state == pifo_pkg::POP) begin
         state <= pifo_pkg::WB;            // Child answers next cycle
      end else begin
         state <= pifo_pkg::IDLE;
      end
   end

   // Command payload, kept until the next accepted command
   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_push_latch <= i_push_value;
         o_node_addr  <= i_my_addr;
      end
   end

   // -------------------------------------------------------------------------
   // Row access
   // -------------------------------------------------------------------------
   // Read with the incoming address so the row is there next cycle
   assign row.rd_en   = accept;
   assign row.rd_addr = i_my_addr;

   // Write back to the row that was read for the current command
   assign row.wr_en   = (state == pifo_pkg::PUSH) || (state == pifo_pkg::WB);
   assign row.wr_addr = o_node_addr;

   assign o_state = state;

endmodule

`default_nettype wire

//--- pifo_min_select.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_min_select (
   input  pifo_pkg::row_t  i_row,
   output pifo_pkg::port_t o_min_count_port,   // Smallest subtree
   output pifo_pkg::port_t o_min_value_port    // Highest priority entry
);

   pifo_pkg::count_t min_count;
   pifo_pkg::value_t min_value;

   // -------------------------------------------------------------------------
   // Smallest subtree
   // -------------------------------------------------------------------------
   // Push target, keeps the four subtrees balanced
   always_comb begin
      min_count        = i_row[0].count;
      o_min_count_port = '0;
      for (int i = 1; i < pifo_pkg::N_PORTS; i++) begin
         // Strict compare so the lowest port wins a tie
         if (i_row[i].count < min_count) begin
            min_count        = i_row[i].count;
            o_min_count_port = pifo_pkg::port_t'(i);
         end
      end
   end

   // -------------------------------------------------------------------------
   // Smallest value
   // -------------------------------------------------------------------------
   // Empty entries read as all ones and lose to any stored value
   always_comb begin
      min_value        = i_row[0].value;
      o_min_value_port = '0;
      for (int i = 1; i < pifo_pkg::N_PORTS; i++) begin
         if (i_row[i].value < min_value) begin
            min_value        = i_row[i].value;
            o_min_value_port = pifo_pkg::port_t'(i);
         end
      end
   end

endmodule

`default_nettype wire

//--- pifo_row_update.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_row_update #(
   parameter int ADW = 4
) (
   input  pifo_pkg::state_t i_state,
   input  pifo_pkg::value_t i_push_latch,    // Value of the accepted push
   input  logic [ADW-1:0]   i_node_addr,
   input  pifo_pkg::value_t i_pop_value,     // Child answer, WB cycle
   pifo_row_if.upd          row,
   output logic             o_push,
   output pifo_pkg::value_t o_push_value,
   output logic             o_pop,
   output pifo_pkg::value_t o_pop_value,
   output logic [ADW+1:0]   o_child_addr
);

   pifo_pkg::port_t  min_count_port;
   pifo_pkg::port_t  min_value_port;
   pifo_pkg::port_t  port;       // Entry the current command works on
   pifo_pkg::entry_t sel;        // Its contents as read
   pifo_pkg::row_t   new_row;

   pifo_min_select pifo_min_select_inst (
      .i_row            (row.rd_row),
      .o_min_count_port (min_count_port),
      .o_min_value_port (min_value_port)
   );

   // Push follows subtree size, pop and write-back follow the head value.
   // rd_row is held from POP into WB, so both cycles see the same port.
   assign port = (i_state == pifo_pkg::PUSH) ? min_count_port : min_value_port;
   assign sel  = row.rd_row[port];

   assign o_child_addr = {i_node_addr, port};   // 4 * node + port

   // -------------------------------------------------------------------------
   // Row update and child commands
   // -------------------------------------------------------------------------
   always_comb begin
      new_row      = row.rd_row;
      o_push       = 1'b0;
      o_push_value = pifo_pkg::EMPTY_VALUE;
      o_pop        = 1'b0;
      o_pop_value  = pifo_pkg::EMPTY_VALUE;

      case (i_state)
         pifo_pkg::PUSH: begin
            new_row[port].count = sel.count + 1'b1;
            if (sel.value == pifo_pkg::EMPTY_VALUE) begin
               new_row[port].value = i_push_latch;   // Free slot, child untouched
            end else if (i_push_latch < sel.value) begin
               // New value takes the slot, stored one moves down
               new_row[port].value = i_push_latch;
               o_push              = 1'b1;
               o_push_value        = sel.value;
            end else begin
               o_push              = 1'b1;           // Stored value stays
               o_push_value        = i_push_latch;
            end
         end

         pifo_pkg::POP: begin
            o_pop       = 1'b1;
            o_pop_value = sel.value;
         end

         pifo_pkg::WB: begin
            new_row[port].value = i_pop_value;       // Child head moves up
            if (sel.count != '0) begin
               new_row[port].count = sel.count - 1'b1;
            end
         end

         default: begin
            // Idle, defaults hold
         end
      endcase
   end

   assign row.wr_row = new_row;

endmodule

`default_nettype wire

//--- pifo_row_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_row_ram #(
   parameter int ADW = 4
) (
   input  logic    i_clk,
   input  logic    i_arst_n,
   pifo_row_if.ram row
);

   localparam int DEPTH = 1 << ADW;

   localparam pifo_pkg::entry_t EMPTY_ENTRY = {pifo_pkg::count_t'(0),
                                               pifo_pkg::EMPTY_VALUE};
   localparam pifo_pkg::row_t   EMPTY_ROW   = {pifo_pkg::N_PORTS{EMPTY_ENTRY}};

   pifo_pkg::row_t mem [DEPTH];

   // -------------------------------------------------------------------------
   // Storage and registered read
   // -------------------------------------------------------------------------
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= EMPTY_ROW;          // Every node starts with no items
         end
         row.rd_row <= EMPTY_ROW;
      end else begin
         if (row.wr_en) begin
            mem[row.wr_addr] <= row.wr_row;
         end
         if (row.rd_en) begin
            // Write-first, a same-cycle write to this row is forwarded
            if (row.wr_en && (row.wr_addr == row.rd_addr)) begin
               row.rd_row <= row.wr_row;
            end else begin
               row.rd_row <= mem[row.rd_addr];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- pifo_node_top.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_node_top #(
   parameter int ADW = pifo_pkg::ADW
) (
   input  logic                     i_clk,
   input  logic                     i_arst_n,
   // Parent side
   input  logic                     i_push,
   input  logic                     i_pop,
   input  logic [pifo_pkg::PTW-1:0] i_push_value,
   output logic [pifo_pkg::PTW-1:0] o_pop_value,
   input  logic [ADW-1:0]           i_my_addr,
   // Child side
   output logic                     o_push,
   output logic [pifo_pkg::PTW-1:0] o_push_value,
   output logic                     o_pop,
   input  logic [pifo_pkg::PTW-1:0] i_pop_value,
   output logic [ADW+1:0]           o_child_addr
);

   pifo_pkg::state_t state;
   pifo_pkg::value_t push_latch;
   logic [ADW-1:0]   node_addr;

   pifo_row_if #(.ADW(ADW)) row_if ();

   // -------------------------------------------------------------------------
   // Command FSM, row update, row storage
   // -------------------------------------------------------------------------
   pifo_node_ctrl #(.ADW(ADW)) pifo_node_ctrl_inst (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (i_push),
      .i_pop        (i_pop),
      .i_push_value (i_push_value),
      .i_my_addr    (i_my_addr),
      .row          (row_if.ctrl),
      .o_state      (state),
      .o_push_latch (push_latch),
      .o_node_addr  (node_addr)
   );

   pifo_row_update #(.ADW(ADW)) pifo_row_update_inst (
      .i_state      (state),
      .i_push_latch (push_latch),
      .i_node_addr  (node_addr),
      .i_pop_value  (i_pop_value),
      .row          (row_if.upd),
      .o_push       (o_push),
      .o_push_value (o_push_value),
      .o_pop        (o_pop),
      .o_pop_value  (o_pop_value),
      .o_child_addr (o_child_addr)
   );

   pifo_row_ram #(.ADW(ADW)) pifo_row_ram_inst (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .row      (row_if.ram)
   );

endmodule

`default_nettype wire

//--- pifo_node_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_node_chk (
   input logic             i_clk,
   input logic             i_arst_n,
   input logic             i_push,         // Parent command pulses
   input logic             i_pop,
   input pifo_pkg::state_t i_state,
   input logic             i_child_push,   // Child command strobes
   input logic             i_child_pop
);

   int unsigned n_fail = 0;
   logic        push_taken;

   // Same accept rule as the node, a push outside the child pop wait
   assign push_taken = i_push && !i_pop && (i_state != pifo_pkg::POP);

   // -------------------------------------------------------------------------
   // Child side protocol
   // -------------------------------------------------------------------------
   a_child_cmd_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !(i_child_push && i_child_pop))
      else begin
         n_fail++;
         $error("child push and child pop are high in the same cycle");
      end

   // Pops take two cycles, the WB cycle follows every child pop
   a_child_pop_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_child_pop |=> !i_child_pop)
      else begin
         n_fail++;
         $error("child pop is high in two consecutive cycles");
      end

   a_child_push_after_push: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_child_push |-> $past(push_taken))
      else begin
         n_fail++;
         $error("child push without an accepted push in the cycle before");
      end

endmodule

`default_nettype wire

//--- tb_pifo_node.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pifo_node;

   localparam int               ADW       = pifo_pkg::ADW;
   localparam int               N_NODES   = 1 << ADW;
   localparam int               N_PORTS   = pifo_pkg::N_PORTS;
   localparam int unsigned      SEED      = 32'he07fa961;
   localparam pifo_pkg::value_t EMPTY     = pifo_pkg::EMPTY_VALUE;

   logic             i_clk;
   logic             i_arst_n;
   logic             i_push;
   logic             i_pop;
   pifo_pkg::value_t i_push_value;
   pifo_pkg::value_t i_pop_value;
   logic [ADW-1:0]   i_my_addr;
   logic             o_push;
   logic             o_pop;
   pifo_pkg::value_t o_push_value;
   pifo_pkg::value_t o_pop_value;
   logic [ADW+1:0]   o_child_addr;

   // Reference model of the node and its four children per row
   pifo_pkg::entry_t ref_row [N_NODES][N_PORTS];
   pifo_pkg::value_t child_q [N_NODES*N_PORTS][$];   // Kept in ascending order
   pifo_pkg::state_t m_state;
   logic             exp_push;
   logic             exp_pop;
   pifo_pkg::value_t exp_push_value;
   pifo_pkg::value_t exp_pop_value;
   logic [ADW+1:0]   exp_child_addr;
   pifo_pkg::value_t child_answer;     // On i_pop_value this cycle
   pifo_pkg::value_t pending_answer;

   pifo_node_top #(.ADW(ADW)) pifo_node_top_inst (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (i_push),
      .i_pop        (i_pop),
      .i_push_value (i_push_value),
      .o_pop_value  (o_pop_value),
      .i_my_addr    (i_my_addr),
      .o_push       (o_push),
      .o_push_value (o_push_value),
      .o_pop        (o_pop),
      .i_pop_value  (i_pop_value),
      .o_child_addr (o_child_addr)
   );

   bind pifo_node_top pifo_node_chk pifo_node_chk_inst (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (i_push),
      .i_pop        (i_pop),
      .i_state      (state),
      .i_child_push (o_push),
      .i_child_pop  (o_pop)
   );

   always #2 i_clk = ~i_clk;

   // -------------------------------------------------------------------------
   // Compare tasks
   // -------------------------------------------------------------------------
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string what, input pifo_pkg::value_t exp_v,
                              input pifo_pkg::value_t act_v);
      if (act_v !== exp_v) begin
         report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                  what, exp_v, act_v));
      end
   endtask

   task automatic check_child_addr(input string what, input logic [ADW+1:0] exp_a,
                                   input logic [ADW+1:0] act_a);
      if (act_a !== exp_a) begin
         report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                  what, exp_a, act_a));
      end
   endtask

   task automatic check_strobe(input string what, input logic exp_b, input logic act_b);
      if (act_b !== exp_b) begin
         report_failure($sformatf("mismatch %s: expected %b, actual %b",
                                  what, exp_b, act_b));
      end
   endtask

   // -------------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------------
   // Smallest count or smallest value with the lowest port on a tie
   function automatic pifo_pkg::port_t min_port(input int node, input bit by_value);
      pifo_pkg::port_t best;
      logic            smaller;
      best = '0;
      for (int p = 1; p < N_PORTS; p++) begin
         smaller = by_value ? (ref_row[node][p].value < ref_row[node][best].value)
                            : (ref_row[node][p].count < ref_row[node][best].count);
         if (smaller) begin
            best = pifo_pkg::port_t'(p);
         end
      end
      return best;
   endfunction

   task automatic model_push(input int node, input pifo_pkg::value_t value);
      pifo_pkg::port_t  p;
      pifo_pkg::value_t stored;
      int               child;
      int               pos;
      p      = min_port(node, 1'b0);
      stored = ref_row[node][p].value;
      child  = node * N_PORTS + int'(p);
      ref_row[node][p].count = ref_row[node][p].count + pifo_pkg::count_t'(1);
      exp_child_addr = child[ADW+1:0];
      if (stored == EMPTY) begin
         ref_row[node][p].value = value;   // Free entry so the child is untouched
      end else begin
         exp_push               = 1'b1;
         exp_push_value         = (value < stored) ? stored : value;
         ref_row[node][p].value = (value < stored) ? value : stored;
         pos = 0;
         while ((pos < child_q[child].size()) && (child_q[child][pos] <= exp_push_value)) begin
            pos++;
         end
         child_q[child].insert(pos, exp_push_value);
      end
   endtask

   task automatic model_pop(input int node);
      pifo_pkg::port_t p;
      int              child;
      p              = min_port(node, 1'b1);
      child          = node * N_PORTS + int'(p);
      exp_pop        = 1'b1;
      exp_pop_value  = ref_row[node][p].value;
      exp_child_addr = child[ADW+1:0];
      // Empty child answers with the empty value
      pending_answer = (child_q[child].size() == 0) ? EMPTY : child_q[child].pop_front();
      ref_row[node][p].value = pending_answer;
      if (ref_row[node][p].count != '0) begin
         ref_row[node][p].count = ref_row[node][p].count - pifo_pkg::count_t'(1);
      end
   endtask

   // -------------------------------------------------------------------------
   // One clock cycle of stimulus and checks
   // -------------------------------------------------------------------------
   task automatic step(input string name, input logic push, input logic pop,
                       input logic [ADW-1:0] addr, input pifo_pkg::value_t value);
      logic accept;
      i_push       <= push;
      i_pop        <= pop;
      i_my_addr    <= addr;
      i_push_value <= value;
      i_pop_value  <= child_answer;
      @(negedge i_clk);
      check_strobe({name, " o_push"}, exp_push, o_push);
      check_strobe({name, " o_pop"}, exp_pop, o_pop);
      check_value({name, " o_pop_value"}, exp_pop_value, o_pop_value);
      if (exp_push) begin
         check_value({name, " o_push_value"}, exp_push_value, o_push_value);
      end
      if (exp_push || exp_pop) begin
         check_child_addr({name, " o_child_addr"}, exp_child_addr, o_child_addr);
      end
      // Outputs expected in the next cycle
      accept        = (push ^ pop) && (m_state != pifo_pkg::POP);
      exp_push      = 1'b0;
      exp_pop       = 1'b0;
      exp_pop_value = EMPTY;
      child_answer  = EMPTY;
      if (accept && push) begin
         model_push(int'(addr), value);
         m_state = pifo_pkg::PUSH;
      end else if (accept) begin
         model_pop(int'(addr));
         m_state = pifo_pkg::POP;
      end else if (m_state == pifo_pkg::POP) begin
         child_answer = pending_answer;   // Child replies in WB
         m_state      = pifo_pkg::WB;
      end else begin
         m_state = pifo_pkg::IDLE;
      end
      @(posedge i_clk);
   endtask

   task automatic random_mix(input string name, input int count);
      int unsigned      r;
      int unsigned      kind;
      logic [ADW-1:0]   addr;
      pifo_pkg::value_t value;
      for (int i = 0; i < count; i++) begin
         r     = $urandom;
         kind  = r[7:0] % 5;
         addr  = ADW'(r[9:8]);                        // Four nodes
         value = pifo_pkg::value_t'({1'b0, r[30:16]}); // Never the empty value
         step(name, (kind < 2) || (kind == 4), (kind == 2) || (kind == 4), addr, value);
      end
   endtask

   task automatic run_command(input string name, input string cmd, input int addr,
                              input int value, input int count);
      logic [ADW-1:0] a;
      a = addr[ADW-1:0];
      if (cmd == "push") begin
         step(name, 1'b1, 1'b0, a, value[15:0]);
      end else if (cmd == "pop") begin
         for (int i = 0; i < count; i++) begin
            step(name, 1'b0, 1'b1, a, '0);
            step(name, 1'b0, 1'b0, a, '0);   // POP cycle so the next command lands in WB
         end
      end else if (cmd == "push_burst") begin
         for (int i = 0; i < count; i++) begin
            step(name, 1'b1, 1'b0, a, pifo_pkg::value_t'((value + i * 'h3a7) & 'h7fff));
         end
      end else if (cmd == "random") begin
         random_mix(name, count);
      end else begin
         report_failure({"unknown command ", cmd, " in case ", name});
      end
   endtask

   task automatic run_cases();
      int    fd;
      int    n;
      string line;
      string name;
      string cmd;
      int    addr;
      int    value;
      int    count;
      fd = $fopen("pifo_node_cases.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open pifo_node_cases.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if ((n > 1) && (line[0] != "#")) begin
            n = $sscanf(line, "%s %s %h %h %d", name, cmd, addr, value, count);
            if (n != 5) begin
               report_failure({"malformed line in the cases file: ", line});
            end
            run_command(name, cmd, addr, value, count);
         end
      end
      $fclose(fd);
   endtask

   initial begin
      void'($urandom(SEED));
      i_clk        = 1'b0;
      i_arst_n     = 1'b0;
      i_push       = 1'b0;
      i_pop        = 1'b0;
      i_push_value = '0;
      i_pop_value  = EMPTY;
      i_my_addr    = '0;
      m_state      = pifo_pkg::IDLE;
      exp_push     = 1'b0;
      exp_pop      = 1'b0;
      exp_pop_value  = EMPTY;
      exp_push_value = EMPTY;
      exp_child_addr = '0;
      child_answer   = EMPTY;
      pending_answer = EMPTY;
      for (int n = 0; n < N_NODES; n++) begin
         for (int p = 0; p < N_PORTS; p++) begin
            ref_row[n][p].count = '0;
            ref_row[n][p].value = EMPTY;
         end
      end
      repeat (4) @(posedge i_clk);
      i_arst_n <= 1'b1;
      step("after_reset", 1'b0, 1'b0, '0, '0);
      run_cases();
      step("final_idle", 1'b0, 1'b0, '0, '0);
      step("final_idle", 1'b0, 1'b0, '0, '0);
      if (pifo_node_top_inst.pifo_node_chk_inst.n_fail != 0) begin
         report_failure("protocol assertions failed in the node checker");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- pifo_node_cases.txt
# name           command     addr  value  count
# addr and value in hex, count in decimal, unused fields are 0
reset_pop_a0     pop         0     0      1
reset_pop_a9     pop         9     0      2
fill_port0       push        3     0040   0
fill_port1       push        3     0020   0
fill_port2       push        3     0060   0
fill_port3       push        3     0010   0
spill_new        push        3     0008   0
spill_old        push        3     0100   0
spill_mid        push        3     0030   0
drain_a3         pop         3     0      8
burst_a5         push_burst  5     1234   12
drain_a5         pop         5     0      13
burst_a6         push_burst  6     0500   6
pop_a6           pop         6     0      2
push_in_wb       push        6     0002   0
push_back2back   push        6     0003   0
drain_a6         pop         6     0      7
random_mix       random      0     0      400
drain_r0         pop         0     0      64
drain_r1         pop         1     0      64
drain_r2         pop         2     0      64
drain_r3         pop         3     0      64

//--- sim.f
pifo_pkg.sv
pifo_row_if.sv
pifo_node_ctrl.sv
pifo_min_select.sv
pifo_row_update.sv
pifo_row_ram.sv
pifo_node_top.sv
pifo_node_chk.sv
tb_pifo_node.sv

//--- Makefile
TOP := tb_pifo_node
BIN := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: build
	$(BIN) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module pifo_node_top \
		pifo_pkg.sv pifo_row_if.sv pifo_node_ctrl.sv pifo_min_select.sv \
		pifo_row_update.sv pifo_row_ram.sv pifo_node_top.sv

clean:
	rm -rf obj_dir sim.log
